// ==== src/ex_config.svh ====
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// ---------------------------------------------------------------------------
// Execute cluster sizing
// ---------------------------------------------------------------------------

// Data word width
`define XLEN 32

// Completion tag width
`define TAG_W 5

// Booth iterations for the 34-bit extended multiplier
`define MUL_ITERS 17

// Accept edge to completion strobe for a multiply
// 17 iterations plus load plus result register
`define MUL_LAT 19

`endif

// ==== src/isa_pkg.sv ====
`include "ex_config.svh"

package isa_pkg;

    // -----------------------------------------------------------------------
    // Plain data words
    // -----------------------------------------------------------------------
    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [31:0]      inst_t;

    // ALU function codes
    typedef enum logic [4:0] {
        ALU_ADD    = 5'h00,
        ALU_SUB    = 5'h01,
        ALU_SLT    = 5'h02,
        ALU_SLTU   = 5'h03,
        ALU_AND    = 5'h04,
        ALU_OR     = 5'h05,
        ALU_XOR    = 5'h06,
        ALU_SLL    = 5'h07,
        ALU_SRL    = 5'h08,
        ALU_SRA    = 5'h09,
        ALU_MUL    = 5'h0a,
        ALU_MULH   = 5'h0b,
        ALU_MULHSU = 5'h0c,
        ALU_MULHU  = 5'h0d,
        ALU_DIV    = 5'h0e,
        ALU_DIVU   = 5'h0f,
        ALU_REM    = 5'h10,
        ALU_REMU   = 5'h11
    } alu_func_e;

    // Operand A source
    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_NPC  = 2'h1,
        OPA_IS_PC   = 2'h2,
        OPA_IS_ZERO = 2'h3
    } opa_sel_e;

    // Operand B source
    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'h0,
        OPB_IS_I_IMM = 3'h1,
        OPB_IS_S_IMM = 3'h2,
        OPB_IS_B_IMM = 3'h3,
        OPB_IS_U_IMM = 3'h4,
        OPB_IS_J_IMM = 3'h5
    } opb_sel_e;

    // Branch funct3 and its defined codes
    typedef logic [2:0] br_func_t;

    localparam br_func_t BR_BEQ  = 3'b000;
    localparam br_func_t BR_BNE  = 3'b001;
    localparam br_func_t BR_BLT  = 3'b100;
    localparam br_func_t BR_BGE  = 3'b101;
    localparam br_func_t BR_BLTU = 3'b110;
    localparam br_func_t BR_BGEU = 3'b111;

endpackage

// ==== src/ex_pkg.sv ====
`include "ex_config.svh"

package ex_pkg;

    import isa_pkg::*;

    // Completion tag handed out by the issue side
    typedef logic [`TAG_W-1:0] tag_t;

    // -----------------------------------------------------------------------
    // Issue packet into the cluster
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic      valid;
        tag_t      tag;
        inst_t     inst;
        xlen_t     pc;
        xlen_t     npc;
        xlen_t     rs1_value;
        xlen_t     rs2_value;
        alu_func_e alu_func;
        opa_sel_e  opa_sel;
        opb_sel_e  opb_sel;
        logic      cond_branch;
        logic      uncond_branch;
    } issue_pkt_t;

    // Request into the multiply unit
    // Operands already muxed
    typedef struct packed {
        tag_t      tag;
        xlen_t     opa;
        xlen_t     opb;
        alu_func_e alu_func;
    } mul_req_t;

    // -----------------------------------------------------------------------
    // Completion packet out of the cluster
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        xlen_t value;
        logic  take_branch;
    } cmp_pkt_t;

endpackage

// ==== src/alu.sv ====
`include "ex_config.svh"

module alu
    import isa_pkg::*;
(
    input  xlen_t     opa,
    input  xlen_t     opb,
    input  alu_func_e func,
    output xlen_t     result
);

    // Signed views for compare and arithmetic shift
    logic signed [`XLEN-1:0] sopa;
    logic signed [`XLEN-1:0] sopb;

    // Shift amount from low opb bits
    logic [4:0] shamt;

    // Compare flags
    logic lt_signed;
    logic lt_unsigned;

    assign sopa  = opa;
    assign sopb  = opb;
    assign shamt = opb[4:0];

    assign lt_signed   = sopa < sopb;
    assign lt_unsigned = opa < opb;

    // -----------------------------------------------------------------------
    // Function select
    // -----------------------------------------------------------------------
    always_comb begin
        case (func)
            ALU_ADD:  result = opa + opb;
            ALU_SUB:  result = opa - opb;
            // Compares give 0 or 1
            ALU_SLT:  result = xlen_t'(lt_signed);
            ALU_SLTU: result = xlen_t'(lt_unsigned);
            ALU_AND:  result = opa & opb;
            ALU_OR:   result = opa | opb;
            ALU_XOR:  result = opa ^ opb;
            ALU_SLL:  result = opa << shamt;
            ALU_SRL:  result = opa >> shamt;
            ALU_SRA:  result = sopa >>> shamt;
            // Multiply runs in mul_unit
            // Divide and remainder are not built
            default:  result = `XLEN'hfacebeec;
        endcase
    end

    // Known operands and code must give a known result
    always_comb begin
        if (!$isunknown({opa, opb, func})) begin
            a_result_known: assert final (!$isunknown(result))
                else $error("alu result unknown for func %0h", func);
        end
    end

endmodule

// ==== src/branch_unit.sv ====
module branch_unit
    import isa_pkg::*;
(
    input  br_func_t func,
    input  xlen_t    rs1,
    input  xlen_t    rs2,
    input  logic     cond_branch,
    input  logic     uncond_branch,
    output logic     take_branch
);

    // Condition of the conditional branch
    logic cond_true;

    always_comb begin
        case (func)
            BR_BEQ:  cond_true = rs1 == rs2;
            BR_BNE:  cond_true = rs1 != rs2;
            BR_BLT:  cond_true = $signed(rs1) < $signed(rs2);
            BR_BGE:  cond_true = $signed(rs1) >= $signed(rs2);
            BR_BLTU: cond_true = rs1 < rs2;
            BR_BGEU: cond_true = rs1 >= rs2;
            // funct3 2 and 3 undefined
            default: cond_true = 1'b0;
        endcase
    end

    // Jumps always taken
    assign take_branch = uncond_branch || (cond_branch && cond_true);

    // Decoder never marks a branch as both kinds
    always_comb begin
        a_one_branch_kind: assert final (!(cond_branch && uncond_branch))
            else $error("cond_branch and uncond_branch both set");
    end

endmodule

// ==== src/booth_mult.sv ====
`include "ex_config.svh"

module booth_mult (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  logic [`XLEN+1:0]   mcand,
    input  logic [`XLEN+1:0]   mplier,
    output logic [2*`XLEN+3:0] product,
    output logic               done
);

    localparam int OP_W  = `XLEN + 2;
    // Two guard bits for the +-2M partial product
    localparam int ACC_W = OP_W + 2;
    localparam int CNT_W = $clog2(`MUL_ITERS);

    typedef enum logic [1:0] {IDLE, RUN, DONE} state_e;

    state_e           state;
    logic [CNT_W-1:0] cnt;

    // Upper accumulator, multiplier shift register and Booth guard bit
    logic signed [ACC_W-1:0] hi_q;
    logic [OP_W-1:0]         lo_q;
    logic                    guard_q;
    logic signed [ACC_W-1:0] mcand_q;

    // Per iteration datapath
    logic [2:0]                   digit;
    logic signed [ACC_W-1:0]      pp;
    logic signed [ACC_W-1:0]      hi_sum;
    logic signed [ACC_W+OP_W-1:0] shifted;

    // -----------------------------------------------------------------------
    // Radix-4 recoding
    // -----------------------------------------------------------------------
    assign digit = {lo_q[1:0], guard_q};

    always_comb begin
        case (digit)
            3'b001, 3'b010: pp = mcand_q;
            3'b011:         pp = mcand_q <<< 1;
            3'b100:         pp = -(mcand_q <<< 1);
            3'b101, 3'b110: pp = -mcand_q;
            default:        pp = '0;
        endcase
    end

    // Add into the top, then arithmetic shift by two
    assign hi_sum  = hi_q + pp;
    assign shifted = $signed({hi_sum, lo_q}) >>> 2;

    // -----------------------------------------------------------------------
    // Sequencing
    // -----------------------------------------------------------------------
    assign done = (state == RUN) && (cnt == CNT_W'(`MUL_ITERS - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (load) begin
                        state <= RUN;
                        cnt   <= '0;
                    end
                end
                RUN: begin
                    cnt <= cnt + 1'b1;
                    if (done) begin
                        state <= DONE;
                    end
                end
                // Product holds here one cycle
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Accumulator datapath
    always_ff @(posedge clk) begin
        if (load) begin
            mcand_q <= ACC_W'($signed(mcand));
            hi_q    <= '0;
            lo_q    <= mplier;
            guard_q <= 1'b0;
        end else if (state == RUN) begin
            hi_q    <= shifted[ACC_W+OP_W-1:OP_W];
            lo_q    <= shifted[OP_W-1:0];
            guard_q <= lo_q[1];
        end
    end

    // Low 68 bits hold the signed product
    assign product = {hi_q[OP_W-1:0], lo_q};

    a_load_when_idle: assert property (@(posedge clk) disable iff (rst)
        load |-> state == IDLE)
        else $error("booth_mult load while not idle");

endmodule

// ==== src/mul_unit.sv ====
`include "ex_config.svh"

module mul_unit
    import isa_pkg::*;
    import ex_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  mul_req_t req,
    output logic     busy,
    output logic     finishing,
    output xlen_t    result,
    output tag_t     tag
);

    localparam int OP_W = `XLEN + 2;

    // Operand extension
    logic            a_signed;
    logic            b_signed;
    logic [OP_W-1:0] mcand;
    logic [OP_W-1:0] mplier;

    // Booth side
    logic [2*OP_W-1:0] product;
    logic              mult_done;

    // Control
    logic busy_q;
    logic grab_q;
    logic fin_q;

    // Payload held across the multiply
    alu_func_e func_q;
    tag_t      tag_q;
    xlen_t     result_q;

    // -----------------------------------------------------------------------
    // Operand extension by function
    // -----------------------------------------------------------------------
    // MUL takes the low word so any extension works
    assign a_signed = (req.alu_func != ALU_MULHU);
    assign b_signed = (req.alu_func == ALU_MUL) || (req.alu_func == ALU_MULH);

    assign mcand  = {{2{a_signed & req.opa[`XLEN-1]}}, req.opa};
    assign mplier = {{2{b_signed & req.opb[`XLEN-1]}}, req.opb};

    booth_mult booth_mult_i (
        .clk     (clk),
        .rst     (rst),
        .load    (start),
        .mcand   (mcand),
        .mplier  (mplier),
        .product (product),
        .done    (mult_done)
    );

    // -----------------------------------------------------------------------
    // Control flags
    // -----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
            grab_q <= 1'b0;
            fin_q  <= 1'b0;
        end else begin
            // Product final one cycle after done
            grab_q <= mult_done;
            fin_q  <= grab_q;
            if (start) begin
                busy_q <= 1'b1;
            end else if (grab_q) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Tag, function and result word
    always_ff @(posedge clk) begin
        if (start) begin
            func_q <= req.alu_func;
            tag_q  <= req.tag;
        end
        if (grab_q) begin
            result_q <= (func_q == ALU_MUL) ? product[`XLEN-1:0]
                                            : product[2*`XLEN-1:`XLEN];
        end
    end

    assign busy      = busy_q;
    assign finishing = fin_q;
    assign result    = result_q;
    assign tag       = tag_q;

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy)
        else $error("mul_unit start while busy");

    // Completion register takes the result at the MUL_LAT edge
    a_mul_latency: assert property (@(posedge clk) disable iff (rst)
        start |-> ##(`MUL_LAT) finishing)
        else $error("mul_unit finishing not at MUL_LAT");

endmodule

// ==== src/ex_cluster.sv ====
`include "ex_config.svh"

module ex_cluster
    import isa_pkg::*;
    import ex_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  issue_pkt_t issue,
    output logic       issue_ready,
    output cmp_pkt_t   cmp
);

    // Immediates from the instruction word
    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_u;
    xlen_t imm_j;

    // Operand muxes and single cycle results
    xlen_t opa_mux;
    xlen_t opb_mux;
    xlen_t alu_result;
    logic  take_branch;

    // Steering
    logic     is_mul;
    logic     accept;
    logic     alu_fire;
    logic     mul_start;
    mul_req_t mul_req;

    // Multiply unit return
    logic  mul_busy;
    logic  mul_finishing;
    xlen_t mul_result;
    tag_t  mul_tag;

    // Completion register
    logic  cmp_valid_q;
    tag_t  cmp_tag_q;
    xlen_t cmp_value_q;
    logic  cmp_take_q;

    // -----------------------------------------------------------------------
    // Immediate extraction
    // -----------------------------------------------------------------------
    assign imm_i = {{(`XLEN-12){issue.inst[31]}}, issue.inst[31:20]};
    assign imm_s = {{(`XLEN-12){issue.inst[31]}}, issue.inst[31:25], issue.inst[11:7]};
    assign imm_b = {{(`XLEN-13){issue.inst[31]}}, issue.inst[31], issue.inst[7],
                    issue.inst[30:25], issue.inst[11:8], 1'b0};
    assign imm_u = {issue.inst[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){issue.inst[31]}}, issue.inst[31], issue.inst[19:12],
                    issue.inst[20], issue.inst[30:21], 1'b0};

    // Operand A
    always_comb begin
        case (issue.opa_sel)
            OPA_IS_RS1:  opa_mux = issue.rs1_value;
            OPA_IS_NPC:  opa_mux = issue.npc;
            OPA_IS_PC:   opa_mux = issue.pc;
            OPA_IS_ZERO: opa_mux = '0;
            default:     opa_mux = `XLEN'hdeadface;
        endcase
    end

    // Operand B
    always_comb begin
        case (issue.opb_sel)
            OPB_IS_RS2:   opb_mux = issue.rs2_value;
            OPB_IS_I_IMM: opb_mux = imm_i;
            OPB_IS_S_IMM: opb_mux = imm_s;
            OPB_IS_B_IMM: opb_mux = imm_b;
            OPB_IS_U_IMM: opb_mux = imm_u;
            OPB_IS_J_IMM: opb_mux = imm_j;
            default:      opb_mux = `XLEN'hfacefeed;
        endcase
    end

    alu alu_i (
        .opa    (opa_mux),
        .opb    (opb_mux),
        .func   (issue.alu_func),
        .result (alu_result)
    );

    // Branch compares the raw register values
    branch_unit branch_unit_i (
        .func          (issue.inst[14:12]),
        .rs1           (issue.rs1_value),
        .rs2           (issue.rs2_value),
        .cond_branch   (issue.cond_branch),
        .uncond_branch (issue.uncond_branch),
        .take_branch   (take_branch)
    );

    // -----------------------------------------------------------------------
    // Issue steering
    // -----------------------------------------------------------------------
    assign is_mul = (issue.alu_func == ALU_MUL)    || (issue.alu_func == ALU_MULH) ||
                    (issue.alu_func == ALU_MULHSU) || (issue.alu_func == ALU_MULHU);

    // Finishing cycle owns the completion register
    assign issue_ready = !rst && !mul_finishing && !(is_mul && mul_busy);

    assign accept    = issue.valid && issue_ready;
    assign alu_fire  = accept && !is_mul;
    assign mul_start = accept && is_mul;

    assign mul_req = '{tag: issue.tag, opa: opa_mux, opb: opb_mux, alu_func: issue.alu_func};

    mul_unit mul_unit_i (
        .clk       (clk),
        .rst       (rst),
        .start     (mul_start),
        .req       (mul_req),
        .busy      (mul_busy),
        .finishing (mul_finishing),
        .result    (mul_result),
        .tag       (mul_tag)
    );

    // -----------------------------------------------------------------------
    // Completion register
    // -----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmp_valid_q <= 1'b0;
        end else begin
            cmp_valid_q <= alu_fire || mul_finishing;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_fire) begin
            cmp_tag_q   <= issue.tag;
            cmp_value_q <= alu_result;
            cmp_take_q  <= take_branch;
        end else if (mul_finishing) begin
            // Multiplies never branch
            cmp_tag_q   <= mul_tag;
            cmp_value_q <= mul_result;
            cmp_take_q  <= 1'b0;
        end
    end

    assign cmp = '{valid: cmp_valid_q, tag: cmp_tag_q, value: cmp_value_q,
                   take_branch: cmp_take_q};

    a_one_writer: assert property (@(posedge clk) disable iff (rst)
        !(alu_fire && mul_finishing))
        else $error("ALU and multiply completion in the same cycle");

endmodule

// ==== bench/tb_ex_cluster.sv ====
`include "ex_config.svh"

module tb_ex_cluster
    import isa_pkg::*;
    import ex_pkg::*;
();

    localparam int READY_LIMIT = 4 * `MUL_LAT;
    localparam int DRAIN_LIMIT = 4 * `MUL_LAT;
    localparam int NUM_TAGS    = 1 << `TAG_W;

    logic       clk;
    logic       rst;
    issue_pkt_t issue;
    logic       issue_ready;
    cmp_pkt_t   cmp;

    // LCG state and bookkeeping
    logic [31:0] seed;
    int          cyc;
    int          checks;
    int          errors;
    int          pending;
    int          issued;
    int          completed;
    tag_t        next_tag;

    // Scoreboard indexed by tag
    logic  sb_busy  [NUM_TAGS];
    xlen_t sb_value [NUM_TAGS];
    logic  sb_take  [NUM_TAGS];
    int    sb_cyc   [NUM_TAGS];

    alu_func_e single_funcs [14] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    alu_func_e mul_funcs [4] = '{ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};
    xlen_t corner_values [5] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000,
        32'h7fff_ffff, 32'h0000_0001};

    ex_cluster ex_cluster_i (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .issue_ready (issue_ready),
        .cmp         (cmp)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Cycle count for the latency checks
    always @(posedge clk) cyc <= cyc + 1;

    // ------------------------------------------------------------------------
    // Random source and reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] rand32();
        seed = seed * 32'd1103515245 + 32'd12345;
        // Upper half first since the low LCG bits are weak
        return {seed[15:0], seed[31:16]};
    endfunction

    // Corner operands about a third of the time
    function automatic xlen_t pick_value();
        logic [31:0] r;
        r = rand32();
        if (r[2:0] < 3'd3) return corner_values[r[10:8] % 5];
        return rand32();
    endfunction

    function automatic xlen_t sext(input xlen_t v, input int w);
        logic signed [31:0] s;
        s = v << (32 - w);
        return s >>> (32 - w);
    endfunction

    function automatic logic is_mul_func(input alu_func_e f);
        return f inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};
    endfunction

    function automatic xlen_t model_opa(input issue_pkt_t p);
        case (p.opa_sel)
            OPA_IS_RS1: return p.rs1_value;
            OPA_IS_NPC: return p.npc;
            OPA_IS_PC:  return p.pc;
            default:    return '0;
        endcase
    endfunction

    // RV32 immediate formats
    function automatic xlen_t model_opb(input issue_pkt_t p);
        case (p.opb_sel)
            OPB_IS_RS2:   return p.rs2_value;
            OPB_IS_I_IMM: return sext(p.inst[31:20], 12);
            OPB_IS_S_IMM: return sext({p.inst[31:25], p.inst[11:7]}, 12);
            OPB_IS_B_IMM: return sext({p.inst[31], p.inst[7], p.inst[30:25],
                                       p.inst[11:8], 1'b0}, 13);
            OPB_IS_U_IMM: return {p.inst[31:12], 12'h000};
            default:      return sext({p.inst[31], p.inst[19:12], p.inst[20],
                                       p.inst[30:21], 1'b0}, 21);
        endcase
    endfunction

    // Wide arithmetic truncated to the word at the end
    function automatic xlen_t model_value(input issue_pkt_t p);
        xlen_t               a;
        xlen_t               b;
        logic signed [127:0] sa;
        logic signed [127:0] sb;
        logic signed [127:0] ua;
        logic signed [127:0] ub;
        logic signed [127:0] prod;
        a  = model_opa(p);
        b  = model_opb(p);
        sa = $signed(a);
        sb = $signed(b);
        ua = a;
        ub = b;
        case (p.alu_func)
            ALU_ADD:  return xlen_t'(ua + ub);
            ALU_SUB:  return xlen_t'(ua - ub);
            ALU_SLT:  return (sa < sb) ? 32'd1 : 32'd0;
            ALU_SLTU: return (ua < ub) ? 32'd1 : 32'd0;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return xlen_t'(ua << b[4:0]);
            ALU_SRL:  return xlen_t'(ua >> b[4:0]);
            ALU_SRA:  return xlen_t'(sa >>> b[4:0]);
            ALU_MUL: begin
                prod = sa * sb;
                return prod[31:0];
            end
            ALU_MULH: begin
                prod = sa * sb;
                return prod[63:32];
            end
            ALU_MULHSU: begin
                prod = sa * ub;
                return prod[63:32];
            end
            ALU_MULHU: begin
                prod = ua * ub;
                return prod[63:32];
            end
            default:  return 32'hfacebeec;
        endcase
    endfunction

    function automatic logic model_take(input issue_pkt_t p);
        logic hit;
        case (p.inst[14:12])
            3'd0:    hit = p.rs1_value == p.rs2_value;
            3'd1:    hit = p.rs1_value != p.rs2_value;
            3'd4:    hit = $signed(p.rs1_value) < $signed(p.rs2_value);
            3'd5:    hit = !($signed(p.rs1_value) < $signed(p.rs2_value));
            3'd6:    hit = p.rs1_value < p.rs2_value;
            3'd7:    hit = !(p.rs1_value < p.rs2_value);
            default: hit = 1'b0;
        endcase
        if (is_mul_func(p.alu_func)) return 1'b0;
        return p.uncond_branch || (p.cond_branch && hit);
    endfunction

    function automatic issue_pkt_t base_pkt(input alu_func_e f, input opa_sel_e a_sel,
                                            input opb_sel_e b_sel);
        issue_pkt_t p;
        p           = '0;
        p.inst      = rand32();
        p.pc        = rand32() & 32'hffff_fffc;
        p.npc       = p.pc + 32'd4;
        p.rs1_value = pick_value();
        p.rs2_value = pick_value();
        p.alu_func  = f;
        p.opa_sel   = a_sel;
        p.opb_sel   = b_sel;
        return p;
    endfunction

    // ------------------------------------------------------------------------
    // Checks, issue and drain
    // ------------------------------------------------------------------------
    task automatic check_value(input logic ok, input string what);
        checks++;
        a_value: assert (ok) else begin
            errors++;
            $display("ERR %0t %s", $time, what);
        end
    endtask

    task automatic check_rule(input logic ok, input string what);
        checks++;
        a_rule: assert (ok) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    // Called at a falling edge and returns at the falling edge after acceptance
    task automatic send(input issue_pkt_t pkt, output int stalls);
        while (sb_busy[next_tag]) next_tag++;
        pkt.valid = 1'b1;
        pkt.tag   = next_tag;
        next_tag++;
        stalls    = 0;
        issue     = pkt;
        #1;
        // Packet held steady while stalled
        while (!issue_ready && stalls < READY_LIMIT) begin
            @(negedge clk);
            #1;
            stalls++;
        end
        if (!issue_ready) begin
            $display("Timeout: issue_ready stayed low for %0d cycles with tag %0d waiting",
                     READY_LIMIT, pkt.tag);
            $display("test failed");
            $finish;
        end else begin
            sb_busy[pkt.tag]  = 1'b1;
            sb_value[pkt.tag] = model_value(pkt);
            sb_take[pkt.tag]  = model_take(pkt);
            // Completion seen at the falling edge after the strobe rises
            sb_cyc[pkt.tag]   = cyc + 1 + (is_mul_func(pkt.alu_func) ? `MUL_LAT : 0);
            pending++;
            issued++;
            @(negedge clk);
            issue.valid = 1'b0;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        #1;
        while (pending != 0 && n < DRAIN_LIMIT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (pending != 0) begin
            $display("Timeout: %0d operations never completed", pending);
            $display("test failed");
            $finish;
        end else begin
            @(negedge clk);
        end
    endtask

    task automatic report_test(input string name, input int err_before, input int chk_before);
        if (errors == err_before) begin
            $display("%s: ok, %0d checks", name, checks - chk_before);
        end else begin
            $display("%s: %0d of %0d checks wrong", name, errors - err_before,
                     checks - chk_before);
        end
    endtask

    // Completion monitor
    // cmp only moves on rising edges
    always @(negedge clk) begin
        if (!rst && cmp.valid) begin
            check_rule(sb_busy[cmp.tag],
                       $sformatf("Completion arrived for tag %0d, which was not outstanding",
                                 cmp.tag));
            if (sb_busy[cmp.tag]) begin
                check_value(cmp.value == sb_value[cmp.tag],
                            $sformatf("tag %0d value %h expected %h", cmp.tag, cmp.value,
                                      sb_value[cmp.tag]));
                check_value(cmp.take_branch == sb_take[cmp.tag],
                            $sformatf("tag %0d take_branch %b expected %b", cmp.tag,
                                      cmp.take_branch, sb_take[cmp.tag]));
                check_value(cyc == sb_cyc[cmp.tag],
                            $sformatf("tag %0d completed in cycle %0d expected %0d", cmp.tag,
                                      cyc, sb_cyc[cmp.tag]));
                sb_busy[cmp.tag] = 1'b0;
                pending--;
            end
            completed++;
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        int          stalls;
        int          total;
        int          e0;
        int          c0;
        issue_pkt_t  p;
        logic [31:0] r;
        alu_func_e   f;

        seed      = 32'd47;
        cyc       = 0;
        checks    = 0;
        errors    = 0;
        pending   = 0;
        issued    = 0;
        completed = 0;
        next_tag  = '0;
        for (int i = 0; i < NUM_TAGS; i++) sb_busy[i] = 1'b0;
        issue = '0;
        rst   = 1'b1;

        // Reset state
        e0 = errors;
        c0 = checks;
        @(negedge clk);
        check_rule(!issue_ready, "issue_ready was high while reset was asserted");
        @(negedge clk);
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_rule(cmp.valid === 1'b0, "cmp.valid was not low after reset");
            check_rule(issue_ready === 1'b1, "issue_ready was not high after reset");
        end
        report_test("reset", e0, c0);

        // Every single-cycle function against every operand source
        e0 = errors;
        c0 = checks;
        foreach (single_funcs[fi]) begin
            for (int a = 0; a < 4; a++) begin
                for (int b = 0; b < 6; b++) begin
                    repeat (2) begin
                        p = base_pkt(single_funcs[fi], opa_sel_e'(a), opb_sel_e'(b));
                        send(p, stalls);
                        check_rule(stalls == 0, "ALU operation stalled with no multiply");
                    end
                end
            end
        end
        drain();
        report_test("alu sweep", e0, c0);

        // Branch conditions, unused funct3 and jumps
        e0 = errors;
        c0 = checks;
        for (int fn = 0; fn < 8; fn++) begin
            for (int k = 0; k < 3; k++) begin
                repeat (6) begin
                    p = base_pkt(ALU_ADD, OPA_IS_PC, OPB_IS_B_IMM);
                    p.inst[14:12] = fn[2:0];
                    r = rand32();
                    if (r[0]) p.rs2_value = p.rs1_value;
                    p.cond_branch   = (k == 1);
                    p.uncond_branch = (k == 2);
                    send(p, stalls);
                end
            end
        end
        drain();
        report_test("branches", e0, c0);

        // Multiplies on corner pairs and random words
        e0 = errors;
        c0 = checks;
        foreach (mul_funcs[m]) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    p = base_pkt(mul_funcs[m], OPA_IS_RS1, OPB_IS_RS2);
                    p.rs1_value = corner_values[i];
                    p.rs2_value = corner_values[j];
                    send(p, stalls);
                end
            end
            repeat (8) begin
                p = base_pkt(mul_funcs[m], OPA_IS_RS1, OPB_IS_RS2);
                p.rs1_value = rand32();
                p.rs2_value = rand32();
                send(p, stalls);
            end
        end
        drain();
        report_test("multiply", e0, c0);

        // ALU work overlapping a running multiply
        e0 = errors;
        c0 = checks;
        p = base_pkt(ALU_MULHSU, OPA_IS_RS1, OPB_IS_RS2);
        send(p, stalls);
        repeat (4) begin
            p = base_pkt(ALU_XOR, OPA_IS_RS1, OPB_IS_I_IMM);
            send(p, stalls);
            check_rule(stalls == 0, "ALU operation stalled behind a running multiply");
        end
        // Second multiply waits out busy and the finishing cycle
        p = base_pkt(ALU_MUL, OPA_IS_RS1, OPB_IS_RS2);
        send(p, stalls);
        check_rule(stalls == `MUL_LAT - 4,
                   $sformatf("Second multiply stalled %0d cycles instead of %0d",
                             stalls, `MUL_LAT - 4));
        total = 0;
        repeat (24) begin
            r = rand32();
            p = base_pkt(single_funcs[r[3:0] % 10], OPA_IS_RS1, OPB_IS_RS2);
            send(p, stalls);
            total += stalls;
        end
        // Only the finishing cycle blocks the burst
        check_rule(total == 1,
                   $sformatf("ALU burst stalled %0d cycles instead of 1", total));
        drain();
        report_test("overlap", e0, c0);

        // Random mix with idle gaps
        e0 = errors;
        c0 = checks;
        repeat (400) begin
            r = rand32();
            if (r[1:0] == 2'd0) begin
                f = mul_funcs[r[3:2]];
            end else begin
                f = single_funcs[r[7:4] % 14];
            end
            p = base_pkt(f, opa_sel_e'(r[9:8]), opb_sel_e'(r[14:12] % 6));
            if (!is_mul_func(f)) begin
                p.cond_branch   = r[16] & ~r[17];
                p.uncond_branch = r[17] & ~r[16];
            end
            send(p, stalls);
            repeat (r[21:20]) @(negedge clk);
        end
        drain();
        check_rule(completed == issued,
                   $sformatf("%0d operations issued but %0d completions seen",
                             issued, completed));
        report_test("random mix", e0, c0);

        $display("%0d issued, %0d completed, %0d checks, %0d errors",
                 issued, completed, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+src
src/isa_pkg.sv
src/ex_pkg.sv
src/alu.sv
src/branch_unit.sv
src/booth_mult.sv
src/mul_unit.sv
src/ex_cluster.sv
bench/tb_ex_cluster.sv

// ==== Bender.yml ====
package:
  name: ex_cluster

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/isa_pkg.sv
      - src/ex_pkg.sv
      - src/alu.sv
      - src/branch_unit.sv
      - src/booth_mult.sv
      - src/mul_unit.sv
      - src/ex_cluster.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - bench/tb_ex_cluster.sv
